/* Makefile */
# Verilator build and run for the APB I2C master testbench

VERILATOR ?= verilator
TOP       ?= apbI2cTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the pass line shows up in the output
run: build
	$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -x -- "$(PASS_TEXT)" > /dev/null

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* hdl/apbI2cTop.sv */
// APB to I2C master top level
// Register block, TX and RX byte FIFOs, bit timer and sequencer

`timescale 1ns/1ps

module apbI2cTop #(
	parameter int FIFO_DEPTH     = 8,
	parameter int QUARTER_CYCLES = 4
) (
	input  logic        PCLK,
	input  logic        PRESETn,
	input  logic        PSELx,
	input  logic        PENABLE,
	input  logic        PWRITE,
	input  logic [31:0] PADDR,
	input  logic [31:0] PWDATA,
	output logic [31:0] PRDATA,
	output logic        PREADY,
	output logic        PSLVERR,
	output logic        INT_TX,
	output logic        INT_RX,
	output logic        scl,
	output logic        sdaOut,
	output logic        sdaOe,
	input  logic        sdaIn
);

	////////////////////
	// Internal nets
	////////////////////

	logic                            txPush;
	logic [7:0]                      txData;
	logic                            rxPop;
	i2cPkg::i2cCfg                   cfg;
	logic [i2cPkg::timeoutWidth-1:0] timeoutLimit;
	logic                            startCmd;
	logic [7:0]                      txHead;
	logic                            txEmpty;
	logic                            txFull;
	logic [7:0]                      rxHead;
	logic                            rxEmpty;
	logic                            rxFull;
	logic                            txPop;
	logic                            rxPush;
	logic [7:0]                      rxData;
	logic                            errorFlag;
	logic                            timerRun;
	logic                            waitData;
	logic                            quarterTick;
	logic [1:0]                      quarterIndex;
	logic                            starved;

	// Interrupts are plain empty levels
	assign INT_TX = txEmpty;
	assign INT_RX = rxEmpty;

	apbRegs apbRegsInst (
		.PCLK(PCLK), .PRESETn(PRESETn), .PSELx(PSELx), .PENABLE(PENABLE),
		.PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA),
		.rxHead(rxHead), .txFull(txFull), .rxEmpty(rxEmpty), .errorFlag(errorFlag),
		.PRDATA(PRDATA), .PREADY(PREADY), .PSLVERR(PSLVERR),
		.txPush(txPush), .txData(txData), .rxPop(rxPop),
		.cfg(cfg), .timeoutLimit(timeoutLimit), .startCmd(startCmd)
	);

	// APB side pushes, sequencer pops
	byteFifo #(.DEPTH(FIFO_DEPTH)) txFifo (
		.PCLK(PCLK), .PRESETn(PRESETn), .push(txPush), .pushData(txData),
		.pop(txPop), .head(txHead), .empty(txEmpty), .full(txFull)
	);

	// Sequencer pushes, APB side pops
	byteFifo #(.DEPTH(FIFO_DEPTH)) rxFifo (
		.PCLK(PCLK), .PRESETn(PRESETn), .push(rxPush), .pushData(rxData),
		.pop(rxPop), .head(rxHead), .empty(rxEmpty), .full(rxFull)
	);

	bitTimer #(.QUARTER_CYCLES(QUARTER_CYCLES)) timerInst (
		.PCLK(PCLK), .PRESETn(PRESETn), .timerRun(timerRun), .waitData(waitData),
		.timeoutLimit(timeoutLimit), .quarterTick(quarterTick),
		.quarterIndex(quarterIndex), .starved(starved)
	);

	i2cSequencer seqInst (
		.PCLK(PCLK), .PRESETn(PRESETn), .startCmd(startCmd), .cfg(cfg),
		.quarterTick(quarterTick), .quarterIndex(quarterIndex), .starved(starved),
		.txHead(txHead), .txEmpty(txEmpty), .rxFull(rxFull), .sdaIn(sdaIn),
		.timerRun(timerRun), .waitData(waitData), .txPop(txPop), .rxPush(rxPush),
		.rxData(rxData), .scl(scl), .sdaOut(sdaOut), .sdaOe(sdaOe), .errorFlag(errorFlag)
	);

endmodule

/* hdl/apbRegs.sv */
// APB register block for the I2C master
// Decodes TX push, RX pop, config and timeout, raises FIFO and start strobes

`timescale 1ns/1ps

module apbRegs (
	input  logic                               PCLK,
	input  logic                               PRESETn,
	input  logic                               PSELx,
	input  logic                               PENABLE,
	input  logic                               PWRITE,
	input  logic [31:0]                        PADDR,
	input  logic [31:0]                        PWDATA,
	input  logic [7:0]                         rxHead,
	input  logic                               txFull,
	input  logic                               rxEmpty,
	input  logic                               errorFlag,
	output logic [31:0]                        PRDATA,
	output logic                               PREADY,
	output logic                               PSLVERR,
	output logic                               txPush,
	output logic [7:0]                         txData,
	output logic                               rxPop,
	output i2cPkg::i2cCfg                      cfg,
	output logic [i2cPkg::timeoutWidth-1:0]    timeoutLimit,
	output logic                               startCmd
);

	logic access;
	logic hitTx;
	logic hitRx;
	logic hitCfg;
	logic hitTimeout;
	logic badAddr;
	i2cPkg::i2cCfg wrCfg;

	// Access phase of a selected transfer
	assign access = PSELx & PENABLE;

	// Address decode
	assign hitTx      = (PADDR == i2cPkg::regTxData);
	assign hitRx      = (PADDR == i2cPkg::regRxData);
	assign hitCfg     = (PADDR == i2cPkg::regConfig);
	assign hitTimeout = (PADDR == i2cPkg::regTimeout);
	assign badAddr    = ~(hitTx | hitRx | hitCfg | hitTimeout);

	// Zero wait states
	assign PREADY = access;

	// Refused FIFO accesses and sequencer errors all flag the bus
	assign PSLVERR = access & (badAddr | (hitTx & PWRITE & txFull) |
		(hitRx & ~PWRITE & rxEmpty) | errorFlag);

	// FIFO strobes only when the FIFO can take them
	assign txPush = access & PWRITE & hitTx & ~txFull;
	assign txData = PWDATA[7:0];
	assign rxPop  = access & ~PWRITE & hitRx & ~rxEmpty;

	// RX head zero-extended to the bus width
	assign PRDATA = {24'd0, rxHead};

	// Go bit gives a one-cycle start
	assign wrCfg    = i2cPkg::i2cCfg'(PWDATA[13:0]);
	assign startCmd = access & PWRITE & hitCfg & wrCfg.go;

	////////////////////
	// Stored registers
	////////////////////

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			cfg          <= '0;
			timeoutLimit <= '0;
		end
		else if (access && PWRITE)
		begin
			// Go is not kept
			if (hitCfg)
				cfg <= i2cPkg::i2cCfg'({1'b0, PWDATA[12:0]});
			if (hitTimeout)
				timeoutLimit <= PWDATA[i2cPkg::timeoutWidth-1:0];
		end
	end

	// Each strobe lasts one cycle as APB never has two access cycles in a row
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		(startCmd || txPush || rxPop) |=> !(startCmd || txPush || rxPop));

endmodule

/* hdl/bitTimer.sv */
// Bit timer for the I2C master
// Quarter-bit ticks for SCL and a TX starvation counter

`timescale 1ns/1ps

module bitTimer #(
	parameter int QUARTER_CYCLES = 4
) (
	input  logic                            PCLK,
	input  logic                            PRESETn,
	input  logic                            timerRun,
	input  logic                            waitData,
	input  logic [i2cPkg::timeoutWidth-1:0] timeoutLimit,
	output logic                            quarterTick,
	output logic [1:0]                      quarterIndex,
	output logic                            starved
);

	localparam int preWidth = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;

	logic [preWidth-1:0]             prescale;
	logic [i2cPkg::timeoutWidth-1:0] starveCount;

	// One tick per quarter of an SCL period
	assign quarterTick = timerRun && (prescale == preWidth'(QUARTER_CYCLES - 1));

	// Zero limit disables the timeout
	assign starved = waitData && (timeoutLimit != '0) && (starveCount == timeoutLimit);

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn || !timerRun)
		begin
			prescale     <= '0;
			quarterIndex <= 2'd0;
			starveCount  <= '0;
		end
		else
		begin
			prescale <= quarterTick ? '0 : prescale + 1'b1;
			// Phase holds while the sequencer waits for TX data
			if (quarterTick && !waitData)
				quarterIndex <= quarterIndex + 2'd1;
			// Starvation count, saturating at the limit
			if (!waitData)
				starveCount <= '0;
			else if (quarterTick && starveCount != timeoutLimit)
				starveCount <= starveCount + 1'b1;
		end
	end

endmodule

/* hdl/byteFifo.sv */
// Byte FIFO with first-word fall-through head
// Circular buffer, registered empty and full flags

`timescale 1ns/1ps

module byteFifo #(
	parameter int DEPTH = 8
) (
	input  logic       PCLK,
	input  logic       PRESETn,
	input  logic       push,
	input  logic [7:0] pushData,
	input  logic       pop,
	output logic [7:0] head,
	output logic       empty,
	output logic       full
);

	localparam int ptrWidth = $clog2(DEPTH);

	logic [7:0]        mem [DEPTH];
	// Extra MSB tells full from empty
	logic [ptrWidth:0] wrPtr;
	logic [ptrWidth:0] rdPtr;
	logic [ptrWidth:0] wrNext;
	logic [ptrWidth:0] rdNext;
	logic              doPush;
	logic              doPop;

	// Refused requests fall away here
	assign doPush = push & ~full;
	assign doPop  = pop & ~empty;
	assign wrNext = wrPtr + {{ptrWidth{1'b0}}, doPush};
	assign rdNext = rdPtr + {{ptrWidth{1'b0}}, doPop};

	// Head reads straight from the array
	assign head = mem[rdPtr[ptrWidth-1:0]];

	always_ff @(posedge PCLK)
	begin
		if (doPush)
			mem[wrPtr[ptrWidth-1:0]] <= pushData;
	end

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			empty <= 1'b1;
			full  <= 1'b0;
		end
		else
		begin
			wrPtr <= wrNext;
			rdPtr <= rdNext;
			// Flags follow the next pointers
			empty <= (wrNext == rdNext);
			full  <= (wrNext[ptrWidth] != rdNext[ptrWidth]) &&
				(wrNext[ptrWidth-1:0] == rdNext[ptrWidth-1:0]);
		end
	end

	// Callers already check the flags
	assert property (@(posedge PCLK) disable iff (!PRESETn) pop |-> !empty);
	assert property (@(posedge PCLK) disable iff (!PRESETn) push |-> !full);

endmodule

/* hdl/i2cPkg.sv */
// I2C master shared definitions
// Configuration word layout, sequencer states and APB register map

package i2cPkg;

	////////////////////
	// Register widths
	////////////////////

	// Timeout register holds a count of quarter ticks
	localparam int timeoutWidth = 14;

	////////////////////
	// Configuration word
	////////////////////

	// Stored at the config address, bit 0 is the LSB
	typedef struct packed {
		// Write-only start request, never stored
		logic       go;
		// Number of data bytes, zero behaves as one
		logic [4:0] byteCount;
		// 7-bit target address
		logic [6:0] slaveAddr;
		// 1 = read, 0 = write
		logic       readNotWrite;
	} i2cCfg;

	// Sequencer FSM states
	typedef enum logic [3:0] {
		idle,
		start,
		addrBits,
		addrAck,
		writeBits,
		writeAck,
		readBits,
		readAck,
		stop
	} seqState;

	// APB register byte addresses
	typedef enum logic [31:0] {
		regTxData  = 32'd0,
		regRxData  = 32'd4,
		regConfig  = 32'd8,
		regTimeout = 32'd12
	} regAddr;

endpackage

/* hdl/i2cSequencer.sv */
// I2C master sequencer
// START, address, data bytes and STOP, paced by quarter-bit ticks

`timescale 1ns/1ps

module i2cSequencer (
	input  logic          PCLK,
	input  logic          PRESETn,
	input  logic          startCmd,
	input  i2cPkg::i2cCfg cfg,
	input  logic          quarterTick,
	input  logic [1:0]    quarterIndex,
	input  logic          starved,
	input  logic [7:0]    txHead,
	input  logic          txEmpty,
	input  logic          rxFull,
	input  logic          sdaIn,
	output logic          timerRun,
	output logic          waitData,
	output logic          txPop,
	output logic          rxPush,
	output logic [7:0]    rxData,
	output logic          scl,
	output logic          sdaOut,
	output logic          sdaOe,
	output logic          errorFlag
);

	i2cPkg::seqState state;
	logic [2:0]      bitCount;
	logic [4:0]      byteIndex;
	logic [4:0]      lastIndex;
	logic [7:0]      shiftReg;
	logic            ackBit;
	logic            sdaLine;
	logic            loadSlot;

	// Zero byte count runs one byte
	assign lastIndex = (cfg.byteCount == 5'd0) ? 5'd0 : cfg.byteCount - 5'd1;
	assign timerRun  = (state != i2cPkg::idle);

	// Quarter 0 of the first bit of a write byte
	assign loadSlot = (state == i2cPkg::writeBits) && (bitCount == 3'd0) && (quarterIndex == 2'd0);
	assign waitData = loadSlot && txEmpty;
	assign txPop    = quarterTick && loadSlot && !txEmpty;

	// Received byte leaves after the eighth bit, dropped when RX is full
	assign rxPush = quarterTick && (state == i2cPkg::readBits) && (bitCount == 3'd7) &&
		(quarterIndex == 2'd3) && !rxFull;
	assign rxData = shiftReg;

	// Open-drain line as seen from the master
	assign sdaLine = ~sdaOe | sdaOut;

	always_ff @(posedge PCLK)
	begin
		if (!PRESETn)
		begin
			state     <= i2cPkg::idle;
			scl       <= 1'b1;
			sdaOut    <= 1'b1;
			sdaOe     <= 1'b0;
			errorFlag <= 1'b0;
			bitCount  <= 3'd0;
			byteIndex <= 5'd0;
		end
		else
		begin
			if (startCmd)
				errorFlag <= 1'b0;
			if (state == i2cPkg::idle)
			begin
				bitCount  <= 3'd0;
				byteIndex <= 5'd0;
				if (startCmd)
					state <= i2cPkg::start;
			end
			else if (starved)
			begin
				// No TX data in time
				state     <= i2cPkg::stop;
				errorFlag <= 1'b1;
			end
			else if (quarterTick && !waitData)
			begin
				// SCL high on quarter 1, low on quarter 3 except when ending STOP
				if (quarterIndex == 2'd1)
					scl <= 1'b1;
				if (quarterIndex == 2'd3 && state != i2cPkg::stop)
					scl <= 1'b0;
				case (state)
					i2cPkg::start:
					begin
						// SDA falls with SCL high
						if (quarterIndex == 2'd2)
						begin
							sdaOe  <= 1'b1;
							sdaOut <= 1'b0;
						end
						if (quarterIndex == 2'd3)
						begin
							shiftReg <= {cfg.slaveAddr, cfg.readNotWrite};
							state    <= i2cPkg::addrBits;
						end
					end
					i2cPkg::addrBits, i2cPkg::writeBits:
					begin
						if (quarterIndex == 2'd0)
						begin
							sdaOe <= 1'b1;
							// First write bit comes straight from the TX head
							if (loadSlot)
							begin
								sdaOut   <= txHead[7];
								shiftReg <= {txHead[6:0], 1'b0};
							end
							else
							begin
								sdaOut   <= shiftReg[7];
								shiftReg <= {shiftReg[6:0], 1'b0};
							end
						end
						if (quarterIndex == 2'd3)
						begin
							bitCount <= bitCount + 3'd1;
							if (bitCount == 3'd7)
								state <= (state == i2cPkg::addrBits) ? i2cPkg::addrAck :
									i2cPkg::writeAck;
						end
					end
					i2cPkg::addrAck, i2cPkg::writeAck:
					begin
						// Release SDA for the slave ACK
						if (quarterIndex == 2'd0)
						begin
							sdaOe  <= 1'b0;
							sdaOut <= 1'b1;
						end
						if (quarterIndex == 2'd2)
							ackBit <= sdaIn;
						if (quarterIndex == 2'd3)
						begin
							if (ackBit)
							begin
								state     <= i2cPkg::stop;
								errorFlag <= 1'b1;
							end
							else if (state == i2cPkg::addrAck)
								state <= cfg.readNotWrite ? i2cPkg::readBits : i2cPkg::writeBits;
							else if (byteIndex == lastIndex)
								state <= i2cPkg::stop;
							else
							begin
								byteIndex <= byteIndex + 5'd1;
								state     <= i2cPkg::writeBits;
							end
						end
					end
					i2cPkg::readBits:
					begin
						if (quarterIndex == 2'd0)
						begin
							sdaOe  <= 1'b0;
							sdaOut <= 1'b1;
						end
						// MSB first
						if (quarterIndex == 2'd2)
							shiftReg <= {shiftReg[6:0], sdaIn};
						if (quarterIndex == 2'd3)
						begin
							bitCount <= bitCount + 3'd1;
							if (bitCount == 3'd7)
							begin
								state <= i2cPkg::readAck;
								// Byte lost to a full RX FIFO
								if (rxFull)
									errorFlag <= 1'b1;
							end
						end
					end
					i2cPkg::readAck:
					begin
						// ACK every byte but the last
						if (quarterIndex == 2'd0)
						begin
							sdaOe  <= 1'b1;
							sdaOut <= (byteIndex == lastIndex);
						end
						if (quarterIndex == 2'd3)
						begin
							if (byteIndex == lastIndex)
								state <= i2cPkg::stop;
							else
							begin
								byteIndex <= byteIndex + 5'd1;
								state     <= i2cPkg::readBits;
							end
						end
					end
					i2cPkg::stop:
					begin
						// SDA low, SCL up, then SDA rises
						if (quarterIndex == 2'd0)
						begin
							sdaOe  <= 1'b1;
							sdaOut <= 1'b0;
						end
						if (quarterIndex == 2'd2)
						begin
							sdaOe  <= 1'b0;
							sdaOut <= 1'b1;
						end
						if (quarterIndex == 2'd3)
							state <= i2cPkg::idle;
					end
					default:
						state <= i2cPkg::idle;
				endcase
			end
		end
	end

	// SDA only moves under high SCL for START and STOP
	assert property (@(posedge PCLK) disable iff (!PRESETn)
		(scl && $past(scl) && state != i2cPkg::start && state != i2cPkg::stop) |->
		$stable(sdaLine));

endmodule

/* tb.f */
hdl/i2cPkg.sv
hdl/apbRegs.sv
hdl/byteFifo.sv
hdl/bitTimer.sv
hdl/i2cSequencer.sv
hdl/apbI2cTop.sv
test/apbI2cTb.sv

/* test/apbI2cTb.sv */
// Testbench for the APB I2C master
// Drives APB accesses, models an I2C slave on the pins and checks transfers,
// error responses and interrupt levels

`timescale 1ns/1ps

module apbI2cTb;

	localparam int fifoDepth     = 8;
	localparam int quarterCycles = 4;
	// Bus bytes over all tests, address bytes included, plus the starvation stall
	localparam int busBytes      = 16;
	localparam int stallQuarters = 20;
	localparam int cycleLimit    = (busBytes * 9 * 4 + stallQuarters) * quarterCycles + 1500;
	localparam int stopWaitLimit = 8 * 9 * 4 * quarterCycles;
	localparam logic [6:0] slaveAddress = 7'h52;

	// Slave model phases
	localparam int pIdle     = 0;
	localparam int pAddr     = 1;
	localparam int pAddrAck  = 2;
	localparam int pWrite    = 3;
	localparam int pWriteAck = 4;
	localparam int pRead     = 5;
	localparam int pReadAck  = 6;

	logic        PCLK;
	logic        PRESETn;
	logic        PSELx;
	logic        PENABLE;
	logic        PWRITE;
	logic [31:0] PADDR;
	logic [31:0] PWDATA;
	logic [31:0] PRDATA;
	logic        PREADY;
	logic        PSLVERR;
	logic        INT_TX;
	logic        INT_RX;
	logic        scl;
	logic        sdaOut;
	logic        sdaOe;
	logic        sdaBus;
	logic        slaveSda;

	int          errorCount = 0;
	int          checkCount = 0;
	int          cycleCount = 0;

	// Slave model state
	int          phase;
	int          bitCnt;
	int          stopCount = 0;
	logic        prevScl;
	logic        prevSda;
	logic        sclNow;
	logic        sdaNow;
	logic [7:0]  shiftIn;
	logic [7:0]  outByte;
	logic [7:0]  lastAddrByte;
	logic        addrMatch;
	logic        readMode;
	logic        masterAck;
	logic [3:0]  readIdx;
	logic [7:0]  readTable [16];
	logic [7:0]  writtenQ [$];

	// Open-drain line, master and slave pull low
	assign sdaBus = (sdaOe ? sdaOut : 1'b1) & slaveSda;

	apbI2cTop #(
		.FIFO_DEPTH(fifoDepth),
		.QUARTER_CYCLES(quarterCycles)
	) apbI2cTop_inst (
		.PCLK(PCLK), .PRESETn(PRESETn), .PSELx(PSELx), .PENABLE(PENABLE),
		.PWRITE(PWRITE), .PADDR(PADDR), .PWDATA(PWDATA), .PRDATA(PRDATA),
		.PREADY(PREADY), .PSLVERR(PSLVERR), .INT_TX(INT_TX), .INT_RX(INT_RX),
		.scl(scl), .sdaOut(sdaOut), .sdaOe(sdaOe), .sdaIn(sdaBus)
	);

	initial
	begin
		PCLK = 1'b0;
		forever
			#2 PCLK = ~PCLK;
	end

	////////////////////
	// Watchdog
	////////////////////

	initial
	begin
		while (cycleCount < cycleLimit)
		begin
			@(posedge PCLK);
			cycleCount = cycleCount + 1;
		end
		$display("Run stopped after %0d cycles without finishing the tests", cycleLimit);
		$display("=== FAIL ===");
		$finish;
	end

	////////////////////
	// Bus protocol checks
	////////////////////

	// Zero wait states
	assert property (@(posedge PCLK) disable iff (!PRESETn) (PSELx && PENABLE) |-> PREADY)
	else
	begin
		$display("PREADY was low in an APB access cycle at %0t ns", $time);
		errorCount = errorCount + 1;
	end

	// Error response only inside an access cycle
	assert property (@(posedge PCLK) disable iff (!PRESETn) !(PSELx && PENABLE) |-> !PSLVERR)
	else
	begin
		$display("PSLVERR was high outside an APB access cycle at %0t ns", $time);
		errorCount = errorCount + 1;
	end

	// Released SDA always reads as high
	assert property (@(posedge PCLK) disable iff (!PRESETn) !sdaOe |-> sdaOut)
	else
	begin
		$display("sdaOut was low while SDA was released at %0t ns", $time);
		errorCount = errorCount + 1;
	end

	////////////////////
	// I2C slave model
	////////////////////

	// Samples the pins 1 ns after each clock edge, ACKs only its own address
	initial
	begin
		forever
		begin
			@(posedge PCLK);
			#1;
			sclNow = scl;
			sdaNow = sdaBus;
			if (!PRESETn)
			begin
				sclNow = 1'b1;
				sdaNow = 1'b1;
				phase  = pIdle;
			end
			else if (prevScl && sclNow && prevSda && !sdaNow)
			begin
				// START
				phase   = pAddr;
				bitCnt  = 0;
				shiftIn = 8'd0;
			end
			else if (prevScl && sclNow && !prevSda && sdaNow)
			begin
				// STOP
				phase     = pIdle;
				slaveSda  = 1'b1;
				stopCount = stopCount + 1;
			end
			else if (!prevScl && sclNow)
			begin
				// Rising SCL, data is valid
				case (phase)
					pAddr, pWrite:
					begin
						shiftIn = {shiftIn[6:0], sdaNow};
						bitCnt  = bitCnt + 1;
					end
					pReadAck:
						masterAck = !sdaNow;
					default:
						;
				endcase
			end
			else if (prevScl && !sclNow)
			begin
				// Falling SCL, slave may change SDA
				case (phase)
					pAddr:
						if (bitCnt == 8)
						begin
							lastAddrByte = shiftIn;
							addrMatch    = (shiftIn[7:1] == slaveAddress);
							readMode     = shiftIn[0];
							slaveSda     = !addrMatch;
							phase        = pAddrAck;
						end
					pWrite:
						if (bitCnt == 8)
						begin
							writtenQ.push_back(shiftIn);
							slaveSda = 1'b0;
							phase    = pWriteAck;
						end
					pAddrAck:
					begin
						slaveSda = 1'b1;
						bitCnt   = 0;
						shiftIn  = 8'd0;
						if (!addrMatch)
							phase = pIdle;
						else if (readMode)
						begin
							outByte  = readTable[readIdx];
							slaveSda = outByte[7];
							phase    = pRead;
						end
						else
							phase = pWrite;
					end
					pWriteAck:
					begin
						slaveSda = 1'b1;
						bitCnt   = 0;
						phase    = pWrite;
					end
					pRead:
					begin
						bitCnt = bitCnt + 1;
						if (bitCnt == 8)
						begin
							// Let the master drive ACK or NACK
							slaveSda = 1'b1;
							readIdx  = readIdx + 4'd1;
							phase    = pReadAck;
						end
						else
						begin
							outByte  = outByte << 1;
							slaveSda = outByte[7];
						end
					end
					pReadAck:
						if (masterAck)
						begin
							bitCnt   = 0;
							outByte  = readTable[readIdx];
							slaveSda = outByte[7];
							phase    = pRead;
						end
						else
							phase = pIdle;
					default:
						;
				endcase
			end
			prevScl = sclNow;
			prevSda = sdaNow;
		end
	end

	////////////////////
	// Helper tasks
	////////////////////

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		checkCount = checkCount + 1;
		assert (got === expected)
		else
		begin
			$display("ERROR %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
			errorCount = errorCount + 1;
		end
	endtask

	// One APB transfer, response sampled late in the access cycle
	task automatic apbAccess(input logic write, input logic [31:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		@(posedge PCLK);
		#1;
		PSELx   = 1'b1;
		PENABLE = 1'b0;
		PWRITE  = write;
		PADDR   = addr;
		PWDATA  = wdata;
		@(posedge PCLK);
		#1;
		PENABLE = 1'b1;
		#2;
		rdata = PRDATA;
		err   = PSLVERR;
		@(posedge PCLK);
		#1;
		PSELx   = 1'b0;
		PENABLE = 1'b0;
	endtask

	// Config write with go, then wait for STOP and the return to idle
	task automatic runTransfer(input logic rnw, input logic [6:0] addr,
		input logic [4:0] count);
		logic [31:0] cfgWord;
		logic [31:0] rdata;
		logic        err;
		int          stopsBefore;
		int          waited;
		// go at bit 13, count at 12:8, address at 7:1, direction at 0
		cfgWord     = (32'd1 << 13) | (32'(count) << 8) | (32'(addr) << 1) | 32'(rnw);
		stopsBefore = stopCount;
		waited      = 0;
		apbAccess(1'b1, 32'd8, cfgWord, rdata, err);
		while (stopCount == stopsBefore && waited < stopWaitLimit)
		begin
			@(posedge PCLK);
			waited = waited + 1;
		end
		if (stopCount == stopsBefore)
		begin
			$display("No STOP on the bus within %0d cycles at %0t ns", stopWaitLimit, $time);
			errorCount = errorCount + 1;
		end
		// Sequencer leaves stop one quarter after the STOP edge
		repeat (quarterCycles + 2)
			@(posedge PCLK);
	endtask

	// A good one-byte read clears the sequencer error, then the byte is popped
	task automatic clearErrorByRead();
		logic [31:0] rdata;
		logic        err;
		logic [3:0]  idx;
		idx = readIdx;
		runTransfer(1'b1, slaveAddress, 5'd1);
		apbAccess(1'b0, 32'd8, 32'd0, rdata, err);
		checkValue("PSLVERR after restart", 32'(err), 32'd0);
		apbAccess(1'b0, 32'd4, 32'd0, rdata, err);
		checkValue("PRDATA", rdata, 32'(readTable[idx]));
		checkValue("PSLVERR on pop", 32'(err), 32'd0);
	endtask

	task automatic reportTest(input int num, input string name, input int errBefore);
		if (errorCount == errBefore)
			$display("Test %0d %s: passed", num, name);
		else
			$display("Test %0d %s: failed with %0d errors", num, name, errorCount - errBefore);
	endtask

	////////////////////
	// Tests
	////////////////////

	initial
	begin
		logic [31:0] rdata;
		logic        err;
		int          errBefore;
		logic [7:0]  txBytes [3];
		logic [7:0]  starveByte;

		PRESETn  = 1'b0;
		PSELx    = 1'b0;
		PENABLE  = 1'b0;
		PWRITE   = 1'b0;
		PADDR    = 32'd0;
		PWDATA   = 32'd0;
		slaveSda = 1'b1;
		readIdx  = 4'd0;
		void'($urandom(32'h374a_4127));
		foreach (readTable[i])
			readTable[i] = 8'($urandom);
		repeat (8)
			@(posedge PCLK);
		#1;
		PRESETn = 1'b1;

		// 1: reset levels
		errBefore = errorCount;
		checkValue("INT_TX", 32'(INT_TX), 32'd1);
		checkValue("INT_RX", 32'(INT_RX), 32'd1);
		checkValue("scl", 32'(scl), 32'd1);
		checkValue("sdaOe", 32'(sdaOe), 32'd0);
		apbAccess(1'b0, 32'd8, 32'd0, rdata, err);
		checkValue("PSLVERR on config read", 32'(err), 32'd0);
		reportTest(1, "reset state", errBefore);

		// 2: three bytes out to the slave
		errBefore = errorCount;
		writtenQ.delete();
		for (int i = 0; i < 3; i++)
		begin
			txBytes[i] = 8'($urandom);
			apbAccess(1'b1, 32'd0, 32'(txBytes[i]), rdata, err);
			checkValue("PSLVERR on push", 32'(err), 32'd0);
		end
		checkValue("INT_TX", 32'(INT_TX), 32'd0);
		runTransfer(1'b0, slaveAddress, 5'd3);
		checkValue("slave address byte", 32'(lastAddrByte), 32'hA4);
		checkValue("bytes seen by slave", 32'(writtenQ.size()), 32'd3);
		if (writtenQ.size() == 3)
			for (int i = 0; i < 3; i++)
				checkValue("written byte", 32'(writtenQ[i]), 32'(txBytes[i]));
		checkValue("INT_TX", 32'(INT_TX), 32'd1);
		reportTest(2, "write transfer", errBefore);

		// 3: four bytes in from the table
		errBefore = errorCount;
		runTransfer(1'b1, slaveAddress, 5'd4);
		checkValue("slave address byte", 32'(lastAddrByte), 32'hA5);
		checkValue("INT_RX", 32'(INT_RX), 32'd0);
		for (int i = 0; i < 4; i++)
		begin
			apbAccess(1'b0, 32'd4, 32'd0, rdata, err);
			checkValue("PRDATA", rdata, 32'(readTable[i]));
			checkValue("PSLVERR on pop", 32'(err), 32'd0);
		end
		checkValue("INT_RX", 32'(INT_RX), 32'd1);
		reportTest(3, "read transfer", errBefore);

		// 4: unknown address gets no ACK
		errBefore = errorCount;
		writtenQ.delete();
		runTransfer(1'b0, 7'h11, 5'd1);
		checkValue("slave address byte", 32'(lastAddrByte), 32'h22);
		checkValue("bytes seen by slave", 32'(writtenQ.size()), 32'd0);
		apbAccess(1'b0, 32'd8, 32'd0, rdata, err);
		checkValue("PSLVERR after NACK", 32'(err), 32'd1);
		clearErrorByRead();
		reportTest(4, "NACK", errBefore);

		// 5: second byte never arrives
		errBefore = errorCount;
		writtenQ.delete();
		apbAccess(1'b1, 32'd12, 32'd20, rdata, err);
		starveByte = 8'($urandom);
		apbAccess(1'b1, 32'd0, 32'(starveByte), rdata, err);
		runTransfer(1'b0, slaveAddress, 5'd2);
		checkValue("bytes seen by slave", 32'(writtenQ.size()), 32'd1);
		if (writtenQ.size() == 1)
			checkValue("written byte", 32'(writtenQ[0]), 32'(starveByte));
		apbAccess(1'b0, 32'd8, 32'd0, rdata, err);
		checkValue("PSLVERR after timeout", 32'(err), 32'd1);
		reportTest(5, "starvation timeout", errBefore);

		// 6: refused accesses
		errBefore = errorCount;
		clearErrorByRead();
		apbAccess(1'b0, 32'd16, 32'd0, rdata, err);
		checkValue("PSLVERR on address 16", 32'(err), 32'd1);
		apbAccess(1'b0, 32'd4, 32'd0, rdata, err);
		checkValue("PSLVERR on empty pop", 32'(err), 32'd1);
		// Only the push past full is refused
		for (int i = 0; i <= fifoDepth; i++)
		begin
			apbAccess(1'b1, 32'd0, 32'(i), rdata, err);
			checkValue("PSLVERR on push", 32'(err), (i == fifoDepth) ? 32'd1 : 32'd0);
		end
		reportTest(6, "bus errors", errBefore);

		$display("Tests 6, checks %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule
